/* hw/replace_queue.sv */
`timescale 1ns/1ps
`include "wbq_defs.svh"

module replace_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push_valid,
    output logic                    push_ready,
    input  logic [`LINE_TAG_W-1:0]  push_addr,
    input  logic [`LINE_W-1:0]      push_data,
    input  wbq_pkg::dir_state       push_state,
    input  logic                    st_check_en,
    input  logic [`PADDR_W-1:0]     st_check_addr,
    output logic                    st_hit,
    output logic [`WBQ_SLOT_W-1:0]  st_idx,
    input  logic                    snoop_en,
    input  logic                    snoop_clean,
    input  logic [`PADDR_W-1:0]     snoop_addr,
    output logic                    snoop_hit,
    output logic [`LINE_W-1:0]      snoop_data,
    output wbq_pkg::dir_state       snoop_state,
    output logic                    drain_valid,
    output logic [`LINE_TAG_W-1:0]  drain_addr,
    output logic [`LINE_W-1:0]      drain_data,
    output wbq_pkg::dir_state       drain_state,
    input  logic                    drain_take,
    input  logic                    drain_done
);
    import wbq_pkg::*;

    logic [`WBQ_SLOTS-1:0]  valid_q;
    logic [`WBQ_SLOTS-1:0]  prio_q;
    logic [`WBQ_SLOTS-1:0]  busy_q;
    logic [`LINE_TAG_W-1:0] addr_q [`WBQ_SLOTS];
    logic [`LINE_W-1:0]     data_q [`WBQ_SLOTS];
    dir_state               state_q [`WBQ_SLOTS];

    logic [`LINE_TAG_W-1:0] st_line;
    logic [`LINE_TAG_W-1:0] snoop_line;
    logic [`WBQ_SLOTS-1:0]  st_match;
    logic [`WBQ_SLOTS-1:0]  snoop_match;
    logic [`WBQ_SLOTS-1:0]  prio_req;
    logic [`WBQ_SLOTS-1:0]  plain_req;

    logic [`WBQ_SLOTS-1:0]  free_onehot;
    logic [`WBQ_SLOTS-1:0]  prio_onehot;
    logic [`WBQ_SLOTS-1:0]  plain_onehot;
    logic [`WBQ_SLOTS-1:0]  st_onehot;
    logic [`WBQ_SLOTS-1:0]  drain_onehot;
    logic [`WBQ_SLOT_W-1:0] free_idx;
    logic [`WBQ_SLOT_W-1:0] prio_idx;
    logic [`WBQ_SLOT_W-1:0] plain_idx;
    logic [`WBQ_SLOT_W-1:0] st_pick_idx;
    logic [`WBQ_SLOT_W-1:0] snoop_pick_idx;
    logic [`WBQ_SLOT_W-1:0] drain_idx;
    logic                   free_any;
    logic                   prio_any;
    logic                   plain_any;
    logic                   st_any;
    logic                   snoop_any;

    logic                   push_fire;
    logic                   push_bypass;
    logic                   push_alloc;
    logic                   snoop_clean_en;
    logic                   drain_blocked;
    logic [`WBQ_SLOTS-1:0]  alloc_set;
    logic [`WBQ_SLOTS-1:0]  take_set;
    logic [`WBQ_SLOTS-1:0]  st_set;
    logic [`WBQ_SLOTS-1:0]  done_clr;
    logic [`WBQ_SLOTS-1:0]  snoop_clr;

    assign st_line    = st_check_addr[`PADDR_W-1:`LINE_OFF_W];
    assign snoop_line = snoop_addr[`PADDR_W-1:`LINE_OFF_W];

    always_comb begin
        for (int i = 0; i < `WBQ_SLOTS; i++) begin
            st_match[i]    = valid_q[i] && (addr_q[i] == st_line);
            snoop_match[i] = valid_q[i] && (addr_q[i] == snoop_line);
        end
    end

    // Lines already handed to the burst engine are not offered again.
    assign prio_req  = valid_q & prio_q & ~busy_q;
    assign plain_req = valid_q & ~busy_q;

    slot_pick u_pick_free  (.req(~valid_q),   .idx(free_idx),       .onehot(free_onehot),
                            .any(free_any));
    slot_pick u_pick_prio  (.req(prio_req),   .idx(prio_idx),       .onehot(prio_onehot),
                            .any(prio_any));
    slot_pick u_pick_plain (.req(plain_req),  .idx(plain_idx),      .onehot(plain_onehot),
                            .any(plain_any));
    slot_pick u_pick_st    (.req(st_match),   .idx(st_pick_idx),    .onehot(st_onehot),
                            .any(st_any));
    slot_pick u_pick_snoop (.req(snoop_match), .idx(snoop_pick_idx), .onehot(),
                            .any(snoop_any));

    assign push_ready     = free_any;
    assign push_fire      = push_valid && push_ready;
    assign push_bypass    = push_fire && (push_addr == snoop_line);
    assign snoop_clean_en = snoop_en && snoop_clean;

    // A clean snoop of the incoming line means it never needs to be written.
    assign push_alloc = push_fire && !(snoop_clean_en && push_bypass);

    assign drain_idx     = prio_any ? prio_idx : plain_idx;
    assign drain_onehot  = prio_any ? prio_onehot : plain_onehot;
    // Hold the offer back while a clean snoop is removing that very line.
    assign drain_blocked = snoop_clean_en && |(snoop_match & drain_onehot);

    assign drain_valid = plain_any && !drain_blocked;
    assign drain_addr  = addr_q[drain_idx];
    assign drain_data  = data_q[drain_idx];
    assign drain_state = state_q[drain_idx];

    assign alloc_set = push_alloc ? free_onehot : '0;
    assign take_set  = drain_take ? drain_onehot : '0;
    assign st_set    = st_check_en ? st_onehot : '0;
    assign done_clr  = drain_done ? busy_q : '0;
    assign snoop_clr = snoop_clean_en ? (snoop_match & ~busy_q) : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            prio_q  <= '0;
            busy_q  <= '0;
            st_hit  <= 1'b0;
            snoop_hit <= 1'b0;
        end else begin
            valid_q <= (valid_q | alloc_set) & ~done_clr & ~snoop_clr;
            prio_q  <= ((prio_q & ~alloc_set) | st_set) & ~done_clr & ~snoop_clr;
            busy_q  <= (busy_q | take_set) & ~done_clr;
            st_hit  <= st_check_en && st_any;
            if (snoop_en) begin
                snoop_hit <= snoop_any || push_bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_alloc) begin
            addr_q[free_idx]  <= push_addr;
            data_q[free_idx]  <= push_data;
            state_q[free_idx] <= push_state;
        end
        if (st_check_en) begin
            st_idx <= st_pick_idx;
        end
        if (snoop_en) begin
            snoop_data  <= push_bypass ? push_data : data_q[snoop_pick_idx];
            snoop_state <= push_bypass ? push_state : state_q[snoop_pick_idx];
        end
    end

endmodule

/* hw/slot_pick.sv */
`timescale 1ns/1ps
`include "wbq_defs.svh"

module slot_pick (
    input  logic [`WBQ_SLOTS-1:0]  req,
    output logic [`WBQ_SLOT_W-1:0] idx,
    output logic [`WBQ_SLOTS-1:0]  onehot,
    output logic                   any
);

    // Scan from the top so the lowest set bit wins.
    always_comb begin
        idx = '0;
        for (int i = `WBQ_SLOTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = `WBQ_SLOT_W'(i);
            end
        end
    end

    // Two's complement isolates the lowest set bit.
    assign onehot = req & (~req + 1'b1);
    assign any    = |req;

endmodule

/* hw/wb_burst.sv */
`timescale 1ns/1ps
`include "wbq_defs.svh"

module wb_burst (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    drain_valid,
    input  logic [`LINE_TAG_W-1:0]  drain_addr,
    input  logic [`LINE_W-1:0]      drain_data,
    input  wbq_pkg::dir_state       drain_state,
    output logic                    drain_take,
    output logic                    drain_done,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [`PADDR_W-1:0]     awaddr,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output wbq_pkg::ace_wop         awsnoop,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [`DATA_W-1:0]      wdata,
    output logic [`DATA_BYTES-1:0]  wstrb,
    output logic                    wlast,
    input  logic                    bvalid,
    output logic                    bready
);
    import wbq_pkg::*;

    burst_state             state;
    logic [`BEAT_W-1:0]     beat;
    logic [`LINE_TAG_W-1:0] line_addr;
    logic [`LINE_W-1:0]     line_data;
    ace_wop                 line_wop;

    assign drain_take = (state == BS_IDLE) && drain_valid;
    assign drain_done = (state == BS_RESP) && bvalid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= BS_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                BS_IDLE: begin
                    if (drain_take) begin
                        state <= BS_ADDR;
                    end
                end
                BS_ADDR: begin
                    if (awready) begin
                        state <= BS_DATA;
                        beat  <= '0;
                    end
                end
                BS_DATA: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (wlast) begin
                            state <= BS_RESP;
                        end
                    end
                end
                default: begin
                    if (bvalid) begin
                        state <= BS_IDLE;
                    end
                end
            endcase
        end
    end

    // Only a modified line carries data the memory does not have.
    always_ff @(posedge clk) begin
        if (drain_take) begin
            line_addr <= drain_addr;
            line_data <= drain_data;
            line_wop  <= (drain_state == DIR_MODIFIED) ? ACE_WRITE_CLEAN : ACE_WRITE_EVICT;
        end
    end

    assign awvalid = (state == BS_ADDR);
    assign awaddr  = {line_addr, {`LINE_OFF_W{1'b0}}};
    assign awlen   = 8'(`LINE_BEATS - 1);
    assign awsize  = 3'($clog2(`DATA_BYTES));
    assign awburst = 2'b01;
    assign awsnoop = line_wop;

    assign wvalid = (state == BS_DATA);
    assign wdata  = line_data[beat*`DATA_W +: `DATA_W];
    assign wstrb  = {`DATA_BYTES{1'b1}};
    assign wlast  = wvalid && (beat == `BEAT_W'(`LINE_BEATS - 1));
    assign bready = 1'b1;

endmodule

/* hw/wb_top.sv */
`timescale 1ns/1ps
`include "wbq_defs.svh"

module wb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push_valid,
    output logic                    push_ready,
    input  logic [`LINE_TAG_W-1:0]  push_addr,
    input  logic [`LINE_W-1:0]      push_data,
    input  wbq_pkg::dir_state       push_state,
    input  logic                    st_check_en,
    input  logic [`PADDR_W-1:0]     st_check_addr,
    output logic                    st_hit,
    output logic [`WBQ_SLOT_W-1:0]  st_idx,
    input  logic                    snoop_en,
    input  logic                    snoop_clean,
    input  logic [`PADDR_W-1:0]     snoop_addr,
    output logic                    snoop_hit,
    output logic [`LINE_W-1:0]      snoop_data,
    output wbq_pkg::dir_state       snoop_state,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [`PADDR_W-1:0]     awaddr,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output wbq_pkg::ace_wop         awsnoop,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [`DATA_W-1:0]      wdata,
    output logic [`DATA_BYTES-1:0]  wstrb,
    output logic                    wlast,
    input  logic                    bvalid,
    output logic                    bready
);
    import wbq_pkg::*;

    // Handoff of one line from the queue to the burst engine.
    logic                   drain_valid;
    logic [`LINE_TAG_W-1:0] drain_addr;
    logic [`LINE_W-1:0]     drain_data;
    dir_state               drain_state;
    logic                   drain_take;
    logic                   drain_done;

    replace_queue u_queue (.*);

    wb_burst u_burst (.*);

endmodule

/* hw/wbq_pkg.sv */
package wbq_pkg;

    // Coherence state of a line held in the queue.
    typedef enum logic [1:0] {
        DIR_INVALID,
        DIR_SHARED,
        DIR_EXCLUSIVE,
        DIR_MODIFIED
    } dir_state;

    // Snoop opcode carried on AW with each evicted line.
    typedef enum logic [0:0] {
        ACE_WRITE_CLEAN,
        ACE_WRITE_EVICT
    } ace_wop;

    // Phases of one line write burst.
    typedef enum logic [1:0] {
        BS_IDLE,
        BS_ADDR,
        BS_DATA,
        BS_RESP
    } burst_state;

endpackage

/* include/wbq_defs.svh */
`ifndef WBQ_DEFS_SVH
`define WBQ_DEFS_SVH

// Replace queue depth and slot index width.
`define WBQ_SLOTS   4
`define WBQ_SLOT_W  2

// A 16-byte line is addressed by its tag above the byte offset.
`define PADDR_W     32
`define LINE_OFF_W  4
`define LINE_TAG_W  (`PADDR_W - `LINE_OFF_W)

// Bus beats and the line they make up.
`define DATA_W      32
`define DATA_BYTES  4
`define LINE_BEATS  4
`define LINE_W      128
`define BEAT_W      2

`endif

/* verif/wb_sva.sv */
`timescale 1ns/1ps
`include "wbq_defs.svh"

module wb_sva (
    input  logic                   clk,
    input  logic                   rst,
    input  wbq_pkg::burst_state    state,
    input  logic                   awvalid,
    input  logic                   awready,
    input  logic [`PADDR_W-1:0]    awaddr,
    input  wbq_pkg::ace_wop        awsnoop,
    input  logic                   wvalid,
    input  logic                   wready,
    input  logic [`DATA_W-1:0]     wdata,
    input  logic                   wlast,
    input  logic                   drain_done
);
    import wbq_pkg::*;

    int unsigned        fail_count = 0;
    logic [`BEAT_W-1:0] w_beats;
    logic               resp_open;

    // Beats accepted since the address of the current burst.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            w_beats   <= '0;
            resp_open <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                w_beats <= '0;
            end else if (wvalid && wready) begin
                w_beats <= w_beats + 1'b1;
            end
            if (wvalid && wready && wlast) begin
                resp_open <= 1'b1;
            end else if (drain_done) begin
                resp_open <= 1'b0;
            end
        end
    end

    // A stalled AW request keeps its address and opcode.
    assert property (@(posedge clk) disable iff (!rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awsnoop))
        else begin
            $error("AW request changed before awready");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else begin
            $error("W beat changed before wready");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst)
        wlast == (wvalid && w_beats == `BEAT_W'(`LINE_BEATS - 1)))
        else begin
            $error("wlast not on the fourth beat of a burst");
            fail_count++;
        end

    // The queue may only free the slot once the response has arrived.
    assert property (@(posedge clk) disable iff (!rst)
        drain_done |-> state == BS_RESP && resp_open)
        else begin
            $error("drain_done outside the response phase");
            fail_count++;
        end

endmodule

bind wb_burst wb_sva u_sva (.*);

/* verif/wb_tb.sv */
`timescale 1ns/1ps
`include "wbq_defs.svh"

module wb_tb;
    import wbq_pkg::*;

    localparam int TXNS  = 400;
    localparam int LIMIT = TXNS * 40;
    localparam logic [`LINE_TAG_W-1:0] TAG_BASE = 28'h3c5a960;

    logic clk, rst, push_valid, push_ready, st_check_en, st_hit;
    logic snoop_en, snoop_clean, snoop_hit;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [`LINE_TAG_W-1:0]  push_addr;
    logic [`LINE_W-1:0]      push_data, snoop_data;
    logic [`PADDR_W-1:0]     st_check_addr, snoop_addr, awaddr;
    logic [`WBQ_SLOT_W-1:0]  st_idx;
    logic [7:0]              awlen;
    logic [2:0]              awsize;
    logic [1:0]              awburst;
    logic [`DATA_W-1:0]      wdata;
    logic [`DATA_BYTES-1:0]  wstrb;
    dir_state                push_state, snoop_state, exp_sn_state;
    ace_wop                  awsnoop, exp_wop;

    // Reference copy of the queue slots and of the burst in flight.
    logic [`WBQ_SLOTS-1:0]   m_valid, m_prio, m_busy;
    logic [`LINE_TAG_W-1:0]  m_addr [`WBQ_SLOTS];
    logic [`LINE_W-1:0]      m_data [`WBQ_SLOTS];
    dir_state                m_state [`WBQ_SLOTS];
    burst_state              m_phase;
    int                      m_beat;
    logic [`LINE_TAG_W-1:0]  exp_tag;
    logic [`LINE_W-1:0]      exp_line, got_line, exp_sn_data;
    logic [`WBQ_SLOT_W-1:0]  exp_st_idx;
    logic                    exp_st_hit, exp_sn_hit, push_went, resp_due, finished;
    logic [31:0]             lfsr;
    int pushes_left, pushed, cleaned, written, mismatches, failures, cycles;

    wb_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int first_set(input logic [`WBQ_SLOTS-1:0] m);
        for (int i = 0; i < `WBQ_SLOTS; i++) begin
            if (m[i]) return i;
        end
        return -1;
    endfunction

    // A new line never matches one that is still queued or being written.
    function automatic logic [`LINE_TAG_W-1:0] fresh_tag();
        logic [3:0] nib;
        logic       clash;
        nib = 4'(take_bits(4));
        do begin
            clash = 1'b0;
            for (int i = 0; i < `WBQ_SLOTS; i++) begin
                if (m_valid[i] && m_addr[i] == TAG_BASE + `LINE_TAG_W'(nib)) clash = 1'b1;
            end
            if (clash) nib = nib + 4'd1;
        end while (clash);
        return TAG_BASE + `LINE_TAG_W'(nib);
    endfunction

    function automatic logic [`PADDR_W-1:0] random_addr();
        return {TAG_BASE + `LINE_TAG_W'(take_bits(4)), `LINE_OFF_W'(take_bits(4))};
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input logic [`WBQ_SLOT_W-1:0] got,
                             input logic [`WBQ_SLOT_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic [`LINE_W-1:0] got,
                              input logic [`LINE_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`PADDR_W-1:0] got,
                              input logic [`PADDR_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_field(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_state(input string name, input dir_state got, input dir_state exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_wop(input string name, input ace_wop got, input ace_wop exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_bit("push_ready", push_ready, ~&m_valid);
        check_bit("st_hit", st_hit, exp_st_hit);
        if (exp_st_hit) check_idx("st_idx", st_idx, exp_st_idx);
        check_bit("snoop_hit", snoop_hit, exp_sn_hit);
        if (exp_sn_hit) begin
            check_line("snoop_data", snoop_data, exp_sn_data);
            check_state("snoop_state", snoop_state, exp_sn_state);
        end
        check_bit("awvalid", awvalid, m_phase == BS_ADDR);
        check_bit("wvalid", wvalid, m_phase == BS_DATA);
        check_bit("bready", bready, 1'b1);
        if (m_phase == BS_ADDR && awready) begin
            check_addr("awaddr", awaddr, {exp_tag, `LINE_OFF_W'(0)});
            check_wop("awsnoop", awsnoop, exp_wop);
            // Four INCR beats of four bytes each.
            check_field("awlen", awlen, 8'd3);
            check_field("awsize", awsize, 8'd2);
            check_field("awburst", awburst, 8'd1);
        end
        if (m_phase == BS_DATA && wready) begin
            got_line[m_beat*`DATA_W +: `DATA_W] = wdata;
            check_field("wstrb", wstrb, 8'h0f);
            check_bit("wlast", wlast, m_beat == `LINE_BEATS - 1);
            if (m_beat == `LINE_BEATS - 1) check_line("wdata line", got_line, exp_line);
        end
        if (wvalid && wready && wlast) resp_due = 1'b1;
        if (bvalid) resp_due = 1'b0;
    endtask

    task automatic advance_model();
        logic [`WBQ_SLOTS-1:0] st_m, sn_m, aset, sset, tset, dclr, sclr;
        logic bypass, clean_en, alloc, take, done;
        int free_i, pick, st_i, sn_i;
        for (int i = 0; i < `WBQ_SLOTS; i++) begin
            st_m[i] = m_valid[i] && m_addr[i] == st_check_addr[`PADDR_W-1:`LINE_OFF_W];
            sn_m[i] = m_valid[i] && m_addr[i] == snoop_addr[`PADDR_W-1:`LINE_OFF_W];
        end
        free_i    = first_set(~m_valid);
        push_went = push_valid && free_i >= 0;
        bypass    = push_went && push_addr == snoop_addr[`PADDR_W-1:`LINE_OFF_W];
        clean_en  = snoop_en && snoop_clean;
        alloc     = push_went && !(clean_en && bypass);
        // Prioritized idle lines go first, then the lowest idle slot.
        pick = first_set(m_valid & m_prio & ~m_busy);
        if (pick < 0) pick = first_set(m_valid & ~m_busy);
        take = m_phase == BS_IDLE && pick >= 0 && !(clean_en && sn_m[pick]);
        done = m_phase == BS_RESP && bvalid;
        st_i = first_set(st_m);
        sn_i = first_set(sn_m);
        exp_st_hit = st_check_en && st_i >= 0;
        if (exp_st_hit) exp_st_idx = `WBQ_SLOT_W'(st_i);
        if (snoop_en) begin
            exp_sn_hit   = sn_i >= 0 || bypass;
            exp_sn_data  = bypass ? push_data : m_data[sn_i < 0 ? 0 : sn_i];
            exp_sn_state = bypass ? push_state : m_state[sn_i < 0 ? 0 : sn_i];
        end
        aset = '0;
        sset = '0;
        tset = '0;
        if (alloc) aset[free_i] = 1'b1;
        if (exp_st_hit) sset[st_i] = 1'b1;
        if (take) tset[pick] = 1'b1;
        dclr = done ? m_busy : '0;
        sclr = clean_en ? (sn_m & ~m_busy) : '0;
        if (push_went) pushed++;
        if (push_went && !alloc) cleaned++;
        if (done) written++;
        cleaned += $countones(sclr);
        if (take) begin
            exp_tag  = m_addr[pick];
            exp_line = m_data[pick];
            exp_wop  = (m_state[pick] == DIR_MODIFIED) ? ACE_WRITE_CLEAN : ACE_WRITE_EVICT;
        end
        if (alloc) begin
            m_addr[free_i]  = push_addr;
            m_data[free_i]  = push_data;
            m_state[free_i] = push_state;
        end
        m_valid = (m_valid | aset) & ~dclr & ~sclr;
        m_prio  = (m_prio | sset) & ~dclr & ~sclr;
        m_busy  = (m_busy | tset) & ~dclr;
        case (m_phase)
            BS_IDLE: if (take) m_phase = BS_ADDR;
            BS_ADDR: if (awready) begin
                m_phase = BS_DATA;
                m_beat  = 0;
            end
            BS_DATA: if (wready) begin
                if (m_beat == `LINE_BEATS - 1) m_phase = BS_RESP;
                m_beat++;
            end
            default: if (bvalid) m_phase = BS_IDLE;
        endcase
    endtask

    task automatic drive_inputs();
        logic [`LINE_TAG_W-1:0] tag;
        tag = push_addr;
        awready <= 1'(take_bits(1));
        wready  <= 1'(take_bits(1));
        if (bvalid) bvalid <= 1'b0;
        else if (resp_due) bvalid <= 1'(take_bits(1));
        // A held push keeps its payload until the queue accepts it.
        if (!push_valid || push_went) begin
            if (pushes_left > 0 && take_bits(1) != 0) begin
                tag = fresh_tag();
                push_valid <= 1'b1;
                push_addr  <= tag;
                push_data  <= {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
                push_state <= dir_state'(2'(take_bits(2)));
                pushes_left--;
            end else begin
                push_valid <= 1'b0;
            end
        end
        st_check_en   <= pushes_left > 0 && take_bits(2) == 0;
        st_check_addr <= random_addr();
        snoop_en      <= pushes_left > 0 && take_bits(2) == 0;
        snoop_clean   <= 1'(take_bits(1));
        if (take_bits(1) != 0) snoop_addr <= {tag, `LINE_OFF_W'(take_bits(4))};
        else snoop_addr <= random_addr();
    endtask

    initial begin
        lfsr = 32'h7d983074;
        rst = 1'b0;
        push_valid = 1'b0;
        push_addr = '0;
        push_data = '0;
        push_state = DIR_INVALID;
        st_check_en = 1'b0;
        st_check_addr = '0;
        snoop_en = 1'b0;
        snoop_clean = 1'b0;
        snoop_addr = '0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        m_valid = '0;
        m_prio = '0;
        m_busy = '0;
        m_phase = BS_IDLE;
        m_beat = 0;
        exp_st_hit = 1'b0;
        exp_sn_hit = 1'b0;
        push_went = 1'b0;
        resp_due = 1'b0;
        finished = 1'b0;
        pushes_left = TXNS;
        pushed = 0;
        cleaned = 0;
        written = 0;
        mismatches = 0;
        failures = 0;
        cycles = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        while (!finished && cycles < LIMIT) begin
            @(negedge clk);
            compare_outputs();
            finished = pushes_left == 0 && !push_valid && m_valid == '0 &&
                       m_phase == BS_IDLE && !bvalid;
            if (!finished) begin
                advance_model();
                @(posedge clk);
                drive_inputs();
                cycles++;
            end
        end
        // An empty queue starts no further burst.
        if (finished) begin
            repeat (2) begin
                advance_model();
                @(posedge clk);
                drive_inputs();
                @(negedge clk);
                compare_outputs();
            end
        end
        if (!finished) begin
            failures++;
            $display("Timeout: the queue did not drain within %0d cycles", LIMIT);
        end
        if (pushed != TXNS || written != pushed - cleaned) begin
            failures++;
            $display("Line count error: %0d pushed, %0d written, %0d removed by snoops",
                     pushed, written, cleaned);
        end
        failures += dut0.u_burst.u_sva.fail_count;
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
hw/wbq_pkg.sv
hw/slot_pick.sv
hw/replace_queue.sv
hw/wb_burst.sv
hw/wb_top.sv
verif/wb_sva.sv
verif/wb_tb.sv
